// ==== src.f ====
src/wb_pkg.sv
src/wb_map_pkg.sv
src/wbp_skid.sv
src/wbp2classic.sv
src/wbc_ram.sv
src/wb_bridge_top.sv
testbench/wb_bridge_assertions.sv
testbench/tb_wb_bridge.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the bridge testbench with Verilator and run it
# The exit status is nonzero when the build or the run fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f src.f --top-module tb_wb_bridge -Mdir obj_dir \
	&& ./obj_dir/Vtb_wb_bridge \
	|| { echo "Simulation run failed"; exit 1; }

// ==== testbench/tb_wb_bridge.sv ====
////////////////////////////////////////////////////////////
// Testbench for the Wishbone bridge subsystem
// Table driven requests, reference memory, in-order checks
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_wb_bridge
	import wb_pkg::*;
	import wb_map_pkg::*;
;

	localparam int CLK_PERIOD      = 20;
	localparam int RESET_CYCLES    = 5;
	localparam int NUM_TESTS       = 12;
	localparam int CYCLES_PER_TEST = 20;

	// One table row, expected values written out by hand
	typedef struct {
		string            name;
		logic             we;
		logic [WB_AW-1:0] addr;
		logic [WB_DW-1:0] data;
		logic [WB_SW-1:0] sel;
		logic [WB_DW-1:0] exp_data;
		logic             exp_err;
	} test_t;

	test_t tests [NUM_TESTS] = '{
		'{"wr_full_a",  1'b1, 12'h010, 32'h1122_3344, 4'b1111, 32'h0000_0000, 1'b0},
		'{"rd_full_a",  1'b0, 12'h010, 32'h0000_0000, 4'b1111, 32'h1122_3344, 1'b0},
		'{"wr_full_b",  1'b1, 12'h0ff, 32'ha5a5_5a5a, 4'b1111, 32'h0000_0000, 1'b0},
		'{"wr_part_b",  1'b1, 12'h0ff, 32'h0000_c300, 4'b0110, 32'h0000_0000, 1'b0},
		'{"rd_part_b",  1'b0, 12'h0ff, 32'h0000_0000, 4'b1111, 32'ha500_c35a, 1'b0},
		'{"wr_full_c",  1'b1, 12'h000, 32'hdead_beef, 4'b1111, 32'h0000_0000, 1'b0},
		'{"wr_oor",     1'b1, 12'h100, 32'h0000_0000, 4'b1111, 32'h0000_0000, 1'b1},
		'{"rd_oor",     1'b0, 12'hfff, 32'h0000_0000, 4'b1111, 32'h0000_0000, 1'b1},
		'{"rd_full_c",  1'b0, 12'h000, 32'h0000_0000, 4'b1111, 32'hdead_beef, 1'b0},
		'{"wr_lane3_a", 1'b1, 12'h010, 32'h7700_0000, 4'b1000, 32'h0000_0000, 1'b0},
		'{"rd_lane3_a", 1'b0, 12'h010, 32'h0000_0000, 4'b1111, 32'h7722_3344, 1'b0},
		'{"rd_again_b", 1'b0, 12'h0ff, 32'h0000_0000, 4'b1111, 32'ha500_c35a, 1'b0}
	};

	logic             i_clk;
	logic             i_reset;
	wbp_req_t         i_req;
	logic             o_stall;
	wb_rsp_t          o_rsp;
	// Model of the RAM contents, written in table order
	logic [WB_DW-1:0] ref_mem [RAM_DEPTH];
	// Table index of every accepted request still waiting for its answer
	int               pending [$];
	logic [31:0]      lfsr_state = 32'hb6aa;

	wb_bridge_top dut (
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.i_req   (i_req),
		.o_stall (o_stall),
		.o_rsp   (o_rsp)
	);

	// Classic side checks live inside the bridge instance
	bind wbp2classic wb_bridge_assertions u_assertions (
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.i_creq  (o_creq),
		.i_crsp  (i_crsp),
		.i_rsp   (o_rsp)
	);

	initial i_clk = 1'b0;
	always #(CLK_PERIOD / 2) i_clk = ~i_clk;

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	task automatic stop_on_error(input string line);
		$display("%s", line);
		$display("*** TEST FAILED ***");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step for every bit taken
	task automatic take_bits(input int n, output int val);
		val = 0;
		for (int k = 0; k < n; k++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			val = (val << 1) | int'(lfsr_state[0]);
		end
	endtask

	// Checks the row against the address map and model, then updates the model
	task automatic predict(input int idx);
		test_t t;
		logic  oor;
		t   = tests[idx];
		oor = (t.addr >= WB_AW'(RAM_DEPTH));
		assert (oor == t.exp_err)
		else
			stop_on_error($sformatf("Table row %s disagrees with the RAM depth", t.name));
		if (!oor && t.we)
		begin
			// Byte merge, only selected lanes change
			for (int b = 0; b < WB_SW; b++)
			begin
				if (t.sel[b])
					ref_mem[t.addr[RAM_IW-1:0]][8*b +: 8] = t.data[8*b +: 8];
			end
		end
		else if (!oor)
		begin
			assert (ref_mem[t.addr[RAM_IW-1:0]] === t.exp_data)
			else
				stop_on_error($sformatf("Table row %s disagrees with the model", t.name));
		end
	endtask

	////////////////////////////////////////////////////////////
	// Response monitor, sampled mid-cycle where outputs are stable
	////////////////////////////////////////////////////////////

	always @(negedge i_clk)
	begin
		int    idx;
		test_t t;
		if (!i_reset && (o_rsp.ack || o_rsp.err))
		begin
			assert (pending.size() != 0)
			else
				stop_on_error("A response came back with no request outstanding");
			idx = pending.pop_front();
			t   = tests[idx];
			assert ({o_rsp.ack, o_rsp.err} == {!t.exp_err, t.exp_err})
			else
				stop_on_error($sformatf("ERROR: %s ack/err expected %b actual %b", t.name,
					{!t.exp_err, t.exp_err}, {o_rsp.ack, o_rsp.err}));
			// Data only means something on a read ack
			if (!t.we && !t.exp_err)
			begin
				assert (o_rsp.data === t.exp_data)
				else
					stop_on_error($sformatf("ERROR: %s data expected %h actual %h", t.name,
						t.exp_data, o_rsp.data));
			end
		end
	end

	// Budget of cycles per row plus the reset
	initial
	begin
		#((RESET_CYCLES + CYCLES_PER_TEST * NUM_TESTS) * CLK_PERIOD);
		stop_on_error("Watchdog expired before all requests were answered");
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	initial
	begin
		int hold;
		int idle;
		i_reset = 1'b1;
		i_req   = '0;
		repeat (RESET_CYCLES) @(posedge i_clk);
		@(negedge i_clk);
		i_reset = 1'b0;
		// Idle bus right after reset
		repeat (3)
		begin
			@(negedge i_clk);
			assert ({o_rsp.ack, o_rsp.err, o_stall} == 3'b000)
			else
				stop_on_error($sformatf("ERROR: reset_idle expected 000 actual %b",
					{o_rsp.ack, o_rsp.err, o_stall}));
		end
		for (int i = 0; i < NUM_TESTS; i++)
		begin
			predict(i);
			i_req.cyc  = 1'b1;
			i_req.stb  = 1'b1;
			i_req.we   = tests[i].we;
			i_req.addr = tests[i].addr;
			i_req.data = tests[i].data;
			i_req.sel  = tests[i].sel;
			// Stall is registered, so its mid-cycle value holds at the next edge
			while (o_stall)
				@(negedge i_clk);
			pending.push_back(i);
			@(negedge i_clk);
			take_bits(1, hold);
			take_bits(2, idle);
			if (hold == 0)
			begin
				i_req.stb = 1'b0;
				repeat (idle) @(negedge i_clk);
			end
		end
		i_req.stb = 1'b0;
		while (pending.size() != 0)
			@(negedge i_clk);
		// End the run and watch for stray responses
		i_req.cyc = 1'b0;
		repeat (10) @(negedge i_clk);
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// ==== testbench/wb_bridge_assertions.sv ====
////////////////////////////////////////////////////////////
// Bridge protocol checks
// Classic handshake rules and a clean pipelined response
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module wb_bridge_assertions
	import wb_pkg::*;
(
	input  logic     i_clk,
	input  logic     i_reset,
	// Classic request and answer seen by the bridge
	input  wbc_req_t i_creq,
	input  wb_rsp_t  i_crsp,
	// Pipelined response leaving the bridge
	input  wb_rsp_t  i_rsp
);

	// stb must drop for the cycle after any answer
	assert property (@(posedge i_clk) disable iff (i_reset)
		(i_crsp.ack || i_crsp.err) |=> !i_creq.stb)
	else
		$error("Classic stb still high in the cycle after ack or err");

	// Waiting strobe keeps its address
	assert property (@(posedge i_clk) disable iff (i_reset)
		(i_creq.cyc && i_creq.stb && !i_crsp.ack && !i_crsp.err) |=> $stable(i_creq.addr))
	else
		$error("Classic address moved while stb waited for an answer");

	assert property (@(posedge i_clk) disable iff (i_reset)
		!(i_rsp.ack && i_rsp.err))
	else
		$error("Pipelined ack and err high in the same cycle");

endmodule

// ==== src/wb_bridge_top.sv ====
////////////////////////////////////////////////////////////
// Bridge subsystem top level
// Skid buffer, pipelined to classic bridge and RAM slave
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module wb_bridge_top
	import wb_pkg::*;
(
	input  logic     i_clk,
	input  logic     i_reset,
	// Pipelined master port
	input  wbp_req_t i_req,
	output logic     o_stall,
	output wb_rsp_t  o_rsp
);

	// Skid buffer to bridge
	wbp_req_t skid_req;
	logic     bridge_stall;
	// Bridge to RAM and back
	wbc_req_t cls_req;
	wb_rsp_t  cls_rsp;

	////////////////////////////////////////////////////////////
	// Input side
	////////////////////////////////////////////////////////////

	wbp_skid u_skid (
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.i_req   (i_req),
		.o_stall (o_stall),
		.o_req   (skid_req),
		.i_stall (bridge_stall)
	);

	////////////////////////////////////////////////////////////
	// Bridge, answers straight to the master port
	////////////////////////////////////////////////////////////

	wbp2classic u_bridge (
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.i_req   (skid_req),
		.o_stall (bridge_stall),
		.o_rsp   (o_rsp),
		.o_creq  (cls_req),
		.i_crsp  (cls_rsp)
	);

	// Output side
	wbc_ram u_ram (
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.i_req   (cls_req),
		.o_rsp   (cls_rsp)
	);

endmodule

// ==== src/wbc_ram.sv ====
////////////////////////////////////////////////////////////
// Classic Wishbone RAM slave
// Byte-lane writes, fixed wait states, err above the depth
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module wbc_ram
	import wb_pkg::*;
	import wb_map_pkg::*;
(
	input  logic     i_clk,
	input  logic     i_reset,
	// Classic slave port
	input  wbc_req_t i_req,
	output wb_rsp_t  o_rsp
);

	// Storage
	logic [WB_DW-1:0]              mem [RAM_DEPTH];
	// Cycles spent on the current strobe
	logic [$clog2(RAM_WAIT+1)-1:0] wait_cnt;
	// Current strobe already answered
	logic                          served;
	// Response pulse and read data
	logic                          ack_q;
	logic                          err_q;
	logic [WB_DW-1:0]              rd_data;
	// Decode of the current request
	logic                          req_valid;
	logic                          in_range;
	logic [RAM_IW-1:0]             ram_idx;
	logic                          fire;

	assign req_valid = i_req.cyc && i_req.stb;
	// Whole address checked, not just the index bits
	assign in_range  = (i_req.addr < WB_AW'(RAM_DEPTH));
	assign ram_idx   = i_req.addr[RAM_IW-1:0];
	// Cycle in which the access happens and the answer is set
	assign fire      = req_valid && !served && (wait_cnt == RAM_WAIT);

	////////////////////////////////////////////////////////////
	// Wait counter and response pulse
	////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			wait_cnt <= '0;
			served   <= 1'b0;
			ack_q    <= 1'b0;
			err_q    <= 1'b0;
		end
		else
		begin
			// One-cycle pulse by default
			ack_q <= 1'b0;
			err_q <= 1'b0;
			if (!req_valid)
			begin
				// stb low, rearm for the next request
				wait_cnt <= '0;
				served   <= 1'b0;
			end
			else if (fire)
			begin
				served <= 1'b1;
				ack_q  <= in_range;
				err_q  <= !in_range;
			end
			else if (!served)
			begin
				wait_cnt <= wait_cnt + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Memory access
	////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		// Error cycles leave the array untouched
		if (fire && in_range && i_req.we)
		begin
			for (int b = 0; b < WB_SW; b++)
			begin
				if (i_req.sel[b])
					mem[ram_idx][8*b +: 8] <= i_req.data[8*b +: 8];
			end
		end
	end

	// Whole word returned, sel only matters for writes
	always_ff @(posedge i_clk)
	begin
		if (fire && in_range && !i_req.we)
			rd_data <= mem[ram_idx];
	end

	assign o_rsp.ack  = ack_q;
	assign o_rsp.err  = err_q;
	assign o_rsp.data = rd_data;

endmodule

// ==== src/wbp2classic.sv ====
////////////////////////////////////////////////////////////
// Pipelined to classic Wishbone bridge
// Turns each pipelined request into one classic cycle and
// registers the slave's answer back to the pipelined side
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module wbp2classic
	import wb_pkg::*;
(
	input  logic     i_clk,
	input  logic     i_reset,
	// Pipelined slave side
	input  wbp_req_t i_req,
	output logic     o_stall,
	output wb_rsp_t  o_rsp,
	// Classic master side
	output wbc_req_t o_creq,
	input  wb_rsp_t  i_crsp
);

	// Set for one cycle after the slave answers
	logic             returned;
	// Registered response toward the master
	logic             rsp_ack;
	logic             rsp_err;
	logic [WB_DW-1:0] rsp_data;

	////////////////////////////////////////////////////////////
	// Classic request
	////////////////////////////////////////////////////////////

	always_comb
	begin
		o_creq.cyc  = i_req.cyc;
		// Forced low the cycle after ack, ends the classic cycle
		o_creq.stb  = i_req.stb && !returned;
		o_creq.we   = i_req.we;
		o_creq.addr = i_req.addr;
		o_creq.data = i_req.data;
		o_creq.sel  = i_req.sel;
	end

	////////////////////////////////////////////////////////////
	// Returned flag and stall
	////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			returned <= 1'b0;
		else if (!i_req.stb || returned)
			returned <= 1'b0;
		else if (i_crsp.ack || i_crsp.err)
			returned <= 1'b1;
	end

	// Request is taken only once its answer came back
	assign o_stall = !returned;

	////////////////////////////////////////////////////////////
	// Response registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			rsp_ack <= 1'b0;
			rsp_err <= 1'b0;
		end
		else
		begin
			// Outside a cycle nothing is reported
			rsp_ack <= i_req.cyc && i_crsp.ack;
			rsp_err <= i_req.cyc && i_crsp.err;
		end
	end

	// Read data held from the answering cycle
	always_ff @(posedge i_clk)
	begin
		if (i_crsp.ack || i_crsp.err)
			rsp_data <= i_crsp.data;
	end

	assign o_rsp.ack  = rsp_ack;
	assign o_rsp.err  = rsp_err;
	assign o_rsp.data = rsp_data;

endmodule

// ==== src/wbp_skid.sv ====
////////////////////////////////////////////////////////////
// Pipelined request skid buffer
// One-entry buffer so that the upstream stall is a plain
// register and never a path from downstream logic
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module wbp_skid
	import wb_pkg::*;
(
	input  logic     i_clk,
	input  logic     i_reset,
	// Upstream pipelined port
	input  wbp_req_t i_req,
	output logic     o_stall,
	// Downstream pipelined port
	output wbp_req_t o_req,
	input  logic     i_stall
);

	// Buffer holds a request the downstream side refused
	logic     skid_full;
	// Parked request, payload only
	wbp_req_t skid_req;

	////////////////////////////////////////////////////////////
	// Buffer occupancy
	////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset || !i_req.cyc)
		begin
			// Dropping cyc ends the run, nothing stays parked
			skid_full <= 1'b0;
		end
		else if (!skid_full && i_req.stb && i_stall)
		begin
			// Passed through but refused downstream
			skid_full <= 1'b1;
		end
		else if (skid_full && !i_stall)
		begin
			// Parked request finally taken
			skid_full <= 1'b0;
		end
	end

	// Capture the refused request
	always_ff @(posedge i_clk)
	begin
		if (!skid_full && i_req.stb && i_stall)
		begin
			skid_req <= i_req;
		end
	end

	////////////////////////////////////////////////////////////
	// Outputs
	////////////////////////////////////////////////////////////

	// Upstream only sees the registered occupancy flag
	assign o_stall = skid_full;

	always_comb
	begin
		// Parked request wins, else straight through
		o_req = skid_full ? skid_req : i_req;
		// cyc always comes from upstream, unbuffered
		o_req.cyc = i_req.cyc;
		// A parked request is always a valid strobe
		o_req.stb = i_req.cyc && (skid_full || i_req.stb);
	end

endmodule

// ==== src/wb_map_pkg.sv ====
////////////////////////////////////////////////////////////
// RAM map
// Size and response timing of the classic RAM slave
////////////////////////////////////////////////////////////

package wb_map_pkg;

	////////////////////////////////////////////////////////////
	// Geometry
	////////////////////////////////////////////////////////////

	// Number of 32-bit words implemented
	localparam int RAM_DEPTH = 256;

	// Index bits taken from the low end of the word address
	// Addresses at or above RAM_DEPTH answer with err
	localparam int RAM_IW = 8;

	////////////////////////////////////////////////////////////
	// Timing
	////////////////////////////////////////////////////////////

	// Wait states inserted before the ack or err pulse
	localparam int RAM_WAIT = 2;

endpackage

// ==== src/wb_pkg.sv ====
////////////////////////////////////////////////////////////
// Wishbone bus definitions
// Bus widths plus the packed pipelined, classic and response
// bundles that every block of the subsystem shares
////////////////////////////////////////////////////////////

package wb_pkg;

	////////////////////////////////////////////////////////////
	// Bus widths
	////////////////////////////////////////////////////////////

	// Word address width, the bus carries no byte offset
	localparam int WB_AW = 12;
	// Data width
	localparam int WB_DW = 32;
	// One select bit per byte lane
	localparam int WB_SW = WB_DW / 8;

	////////////////////////////////////////////////////////////
	// Request and response bundles
	////////////////////////////////////////////////////////////

	// Pipelined request
	// stb is a one-cycle transfer whenever stall is low
	typedef struct packed {
		logic             cyc;
		logic             stb;
		logic             we;
		logic [WB_AW-1:0] addr;
		logic [WB_DW-1:0] data;
		logic [WB_SW-1:0] sel;
	} wbp_req_t;

	// Classic request
	// stb stays up with a fixed address until ack or err
	typedef struct packed {
		logic             cyc;
		logic             stb;
		logic             we;
		logic [WB_AW-1:0] addr;
		logic [WB_DW-1:0] data;
		logic [WB_SW-1:0] sel;
	} wbc_req_t;

	// Response, same shape on both bus flavors
	typedef struct packed {
		logic             ack;
		logic             err;
		logic [WB_DW-1:0] data;
	} wb_rsp_t;

endpackage
